//--- hw/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  la_decode_pkg::inst_t        inst,
    output la_decode_pkg::decode_ctrl_t ctrl
);
    import la_decode_pkg::*;

    logic [OP_31_26_W-1:0] op_31_26;
    logic [OP_25_22_W-1:0] op_25_22;
    logic [OP_21_20_W-1:0] op_21_20;
    logic [OP_19_15_W-1:0] op_19_15;
    reg_addr_t             rd;
    reg_addr_t             rj;
    reg_addr_t             rk;
    logic [I12_W-1:0]      i12;
    logic [I20_W-1:0]      i20;

    logic      known;
    logic      is_store;
    logic      is_trap;
    ecode_t    trap_code;
    alu_op_e   alu_op;
    imm_kind_e imm_kind;
    logic      src1_is_pc;
    byte_en_t  mem_we;
    byte_en_t  res_from_mem;
    word_t     imm;

    assign op_31_26 = inst[OP_31_26_LSB +: OP_31_26_W];
    assign op_25_22 = inst[OP_25_22_LSB +: OP_25_22_W];
    assign op_21_20 = inst[OP_21_20_LSB +: OP_21_20_W];
    assign op_19_15 = inst[OP_19_15_LSB +: OP_19_15_W];
    assign rd       = inst[RD_LSB +: $bits(reg_addr_t)];
    assign rj       = inst[RJ_LSB +: $bits(reg_addr_t)];
    assign rk       = inst[RK_LSB +: $bits(reg_addr_t)];
    assign i12      = inst[I12_LSB +: I12_W];
    assign i20      = inst[I20_LSB +: I20_W];

    always_comb begin
        known        = 1'b1;
        is_store     = 1'b0;
        is_trap      = 1'b0;
        trap_code    = 8'h00;
        alu_op       = ALU_ADD;
        imm_kind     = IMM_NONE;
        src1_is_pc   = 1'b0;
        mem_we       = 4'b0000;
        res_from_mem = 4'b0000;
        case (op_31_26)
            6'h00: begin
                if (op_25_22 == 4'h0 && op_21_20 == 2'h1) begin
                    case (op_19_15)
                        5'h00:   alu_op = ALU_ADD;
                        5'h02:   alu_op = ALU_SUB;
                        5'h04:   alu_op = ALU_SLT;
                        5'h05:   alu_op = ALU_SLTU;
                        5'h08:   alu_op = ALU_NOR;
                        5'h09:   alu_op = ALU_AND;
                        5'h0a:   alu_op = ALU_OR;
                        5'h0b:   alu_op = ALU_XOR;
                        5'h0e:   alu_op = ALU_SLL;
                        5'h0f:   alu_op = ALU_SRL;
                        5'h10:   alu_op = ALU_SRA;
                        5'h18:   alu_op = ALU_MUL;
                        5'h19:   alu_op = ALU_MULH;
                        5'h1a:   alu_op = ALU_MULHU;
                        default: known = 1'b0;
                    endcase
                end else if (op_25_22 == 4'h0 && op_21_20 == 2'h2) begin
                    case (op_19_15)
                        5'h00: alu_op = ALU_DIV;
                        5'h01: alu_op = ALU_MOD;
                        5'h02: alu_op = ALU_DIVU;
                        5'h03: alu_op = ALU_MODU;
                        5'h14: begin
                            is_trap   = 1'b1;
                            trap_code = ECODE_BRK;
                        end
                        5'h16: begin
                            is_trap   = 1'b1;
                            trap_code = ECODE_SYS;
                        end
                        default: known = 1'b0;
                    endcase
                end else if (op_25_22 == 4'h1 && op_21_20 == 2'h0) begin
                    imm_kind = IMM_UI5;
                    case (op_19_15)
                        5'h01:   alu_op = ALU_SLL;
                        5'h09:   alu_op = ALU_SRL;
                        5'h11:   alu_op = ALU_SRA;
                        default: known = 1'b0;
                    endcase
                end else begin
                    // 12-bit immediate group
                    case (op_25_22)
                        4'h8: begin
                            alu_op   = ALU_SLT;
                            imm_kind = IMM_SI12;
                        end
                        4'h9: begin
                            alu_op   = ALU_SLTU;
                            imm_kind = IMM_SI12;
                        end
                        4'ha: begin
                            alu_op   = ALU_ADD;
                            imm_kind = IMM_SI12;
                        end
                        4'hd: begin
                            alu_op   = ALU_AND;
                            imm_kind = IMM_UI12;
                        end
                        4'he: begin
                            alu_op   = ALU_OR;
                            imm_kind = IMM_UI12;
                        end
                        4'hf: begin
                            alu_op   = ALU_XOR;
                            imm_kind = IMM_UI12;
                        end
                        default: known = 1'b0;
                    endcase
                end
            end
            6'h05: begin
                alu_op   = ALU_LUI;
                imm_kind = IMM_SI20;
                known    = ~op_25_22[3];
            end
            6'h07: begin
                // pcaddu12i
                src1_is_pc = 1'b1;
                imm_kind   = IMM_SI20;
                known      = ~op_25_22[3];
            end
            6'h0a: begin
                // address = rj + si12
                imm_kind = IMM_SI12;
                case (op_25_22)
                    4'h0: res_from_mem = 4'b0001;
                    4'h1: res_from_mem = 4'b0011;
                    4'h2: res_from_mem = 4'b1111;
                    4'h8: res_from_mem = 4'b0101;
                    4'h9: res_from_mem = 4'b0111;
                    4'h4: begin
                        mem_we   = 4'b0001;
                        is_store = 1'b1;
                    end
                    4'h5: begin
                        mem_we   = 4'b0011;
                        is_store = 1'b1;
                    end
                    4'h6: begin
                        mem_we   = 4'b1111;
                        is_store = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        case (imm_kind)
            IMM_UI5:  imm = {27'b0, rk};
            IMM_SI12: imm = {{20{i12[I12_W-1]}}, i12};
            IMM_UI12: imm = {20'b0, i12};
            IMM_SI20: imm = {i20, 12'b0};
            default:  imm = '0;
        endcase
    end

    always_comb begin
        ctrl.alu_op       = alu_op;
        ctrl.imm_kind     = imm_kind;
        ctrl.imm          = imm;
        ctrl.src1_is_pc   = src1_is_pc;
        ctrl.src2_is_imm  = (imm_kind != IMM_NONE);
        ctrl.raddr1       = rj;
        // stores read their data from rd
        ctrl.raddr2       = is_store ? rd : rk;
        ctrl.dest         = rd;
        ctrl.gr_we        = known & ~is_store & ~is_trap;
        ctrl.mem_we       = known ? mem_we : 4'b0000;
        ctrl.res_from_mem = known ? res_from_mem : 4'b0000;
        ctrl.ex           = ~known | is_trap;
        ctrl.ecode        = known ? trap_code : ECODE_INE;
    end

endmodule

`default_nettype wire

//--- hw/inst_latch.sv
`timescale 1ns/1ps
`default_nettype none

module inst_latch (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       flush,
    input  logic                       fd_valid,
    input  la_decode_pkg::fetch_item_t fd_item,
    input  logic                       stall,
    input  logic                       e_allowin,
    output logic                       d_allowin,
    output logic                       d_valid,
    output la_decode_pkg::fetch_item_t d_item
);

    logic ready_go;
    logic accept;

    // item may leave once no load-use hazard holds it
    assign ready_go  = d_valid & ~stall;
    assign d_allowin = ~d_valid | (ready_go & e_allowin);
    assign accept    = fd_valid & d_allowin & ~flush;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            d_valid <= 1'b0;
        end else if (flush) begin
            d_valid <= 1'b0;
        end else if (d_allowin) begin
            d_valid <= fd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            d_item <= fd_item;
        end
    end

endmodule

`default_nettype wire

//--- hw/la_decode_pkg.sv
`default_nettype none

package la_decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [7:0]  ecode_t;

    localparam ecode_t ECODE_SYS = 8'h0b;
    localparam ecode_t ECODE_BRK = 8'h0c;
    localparam ecode_t ECODE_INE = 8'h0d;

    // opcode fields, lsb and width
    localparam int OP_31_26_LSB = 26;
    localparam int OP_31_26_W   = 6;
    localparam int OP_25_22_LSB = 22;
    localparam int OP_25_22_W   = 4;
    localparam int OP_21_20_LSB = 20;
    localparam int OP_21_20_W   = 2;
    localparam int OP_19_15_LSB = 15;
    localparam int OP_19_15_W   = 5;

    // register fields
    localparam int RD_LSB = 0;
    localparam int RJ_LSB = 5;
    localparam int RK_LSB = 10;

    // immediate fields
    localparam int I12_LSB = 10;
    localparam int I12_W   = 12;
    localparam int I20_LSB = 5;
    localparam int I20_W   = 20;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR, ALU_OR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_MUL, ALU_MULH,
        ALU_MULHU, ALU_DIV, ALU_MOD, ALU_DIVU, ALU_MODU
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_UI5,
        IMM_SI12,
        IMM_UI12,
        // upper 20 bits, shifted left by 12
        IMM_SI20
    } imm_kind_e;

    typedef struct packed {
        word_t pc;
        inst_t inst;
    } fetch_item_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_write_t;

    typedef struct packed {
        logic      is_load;
        reg_addr_t dest;
    } ex_hazard_t;

    typedef struct packed {
        alu_op_e   alu_op;
        imm_kind_e imm_kind;
        word_t     imm;
        logic      src1_is_pc;
        logic      src2_is_imm;
        reg_addr_t raddr1;
        reg_addr_t raddr2;
        reg_addr_t dest;
        logic      gr_we;
        byte_en_t  mem_we;
        byte_en_t  res_from_mem;
        logic      ex;
        ecode_t    ecode;
    } decode_ctrl_t;

    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        word_t     src1;
        word_t     src2;
        word_t     store_data;
        reg_addr_t dest;
        logic      gr_we;
        byte_en_t  mem_we;
        byte_en_t  res_from_mem;
        logic      ex;
        ecode_t    ecode;
    } de_item_t;

endpackage

`default_nettype wire

//--- hw/la_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module la_decode_top (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       flush,
    input  logic                       fd_valid,
    input  la_decode_pkg::fetch_item_t fd_item,
    input  logic                       e_allowin,
    input  la_decode_pkg::wb_write_t   wb,
    input  la_decode_pkg::ex_hazard_t  ex_hz,
    output logic                       d_allowin,
    output logic                       de_valid,
    output la_decode_pkg::de_item_t    de_item
);
    import la_decode_pkg::*;

    logic         stall;
    logic         d_valid;
    fetch_item_t  d_item;
    decode_ctrl_t ctrl;
    word_t        rdata1;
    word_t        rdata2;

    // one-entry buffer between fetch and decode
    inst_latch u_latch (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (flush),
        .fd_valid  (fd_valid),
        .fd_item   (fd_item),
        .stall     (stall),
        .e_allowin (e_allowin),
        .d_allowin (d_allowin),
        .d_valid   (d_valid),
        .d_item    (d_item)
    );

    inst_decoder u_decoder (
        .inst (d_item.inst),
        .ctrl (ctrl)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (ctrl.raddr1),
        .raddr2 (ctrl.raddr2),
        .wb     (wb),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    operand_select u_opsel (
        .d_valid  (d_valid),
        .pc       (d_item.pc),
        .ctrl     (ctrl),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .wb       (wb),
        .ex_hz    (ex_hz),
        .stall    (stall),
        .de_valid (de_valid),
        .de_item  (de_item)
    );

endmodule

`default_nettype wire

//--- hw/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select (
    input  logic                        d_valid,
    input  la_decode_pkg::word_t        pc,
    input  la_decode_pkg::decode_ctrl_t ctrl,
    input  la_decode_pkg::word_t        rdata1,
    input  la_decode_pkg::word_t        rdata2,
    input  la_decode_pkg::wb_write_t    wb,
    input  la_decode_pkg::ex_hazard_t   ex_hz,
    output logic                        stall,
    output logic                        de_valid,
    output la_decode_pkg::de_item_t     de_item
);
    import la_decode_pkg::*;

    logic  byp1;
    logic  byp2;
    logic  hz1;
    logic  hz2;
    word_t rj_value;
    word_t rkd_value;

    // write-back data seen in the same cycle as the read
    assign byp1 = wb.we && (wb.addr == ctrl.raddr1) && (ctrl.raddr1 != '0);
    assign byp2 = wb.we && (wb.addr == ctrl.raddr2) && (ctrl.raddr2 != '0);

    assign rj_value  = byp1 ? wb.data : rdata1;
    assign rkd_value = byp2 ? wb.data : rdata2;

    // load in execute has no data yet
    assign hz1   = (ex_hz.dest == ctrl.raddr1);
    assign hz2   = (ex_hz.dest == ctrl.raddr2);
    assign stall = ex_hz.is_load && (ex_hz.dest != '0) && (hz1 || hz2);

    assign de_valid = d_valid & ~stall;

    always_comb begin
        de_item.pc           = pc;
        de_item.alu_op       = ctrl.alu_op;
        de_item.src1         = ctrl.src1_is_pc ? pc : rj_value;
        de_item.src2         = ctrl.src2_is_imm ? ctrl.imm : rkd_value;
        de_item.store_data   = rkd_value;
        de_item.dest         = ctrl.dest;
        de_item.gr_we        = ctrl.gr_we;
        de_item.mem_we       = ctrl.mem_we;
        de_item.res_from_mem = ctrl.res_from_mem;
        de_item.ex           = ctrl.ex;
        de_item.ecode        = ctrl.ecode;
    end

endmodule

`default_nettype wire

//--- hw/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                     clk,
    input  la_decode_pkg::reg_addr_t raddr1,
    input  la_decode_pkg::reg_addr_t raddr2,
    input  la_decode_pkg::wb_write_t wb,
    output la_decode_pkg::word_t     rdata1,
    output la_decode_pkg::word_t     rdata2
);
    import la_decode_pkg::*;

    word_t regs [2**$bits(reg_addr_t)];

    always_ff @(posedge clk) begin
        if (wb.we && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // r0 is hardwired, never written
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- la_decode.f
hw/la_decode_pkg.sv
hw/inst_latch.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/operand_select.sv
hw/la_decode_top.sv
testbench/la_decode_chk.sv
testbench/tb_la_decode.sv

//--- testbench/la_decode_chk.sv
`timescale 1ns/1ps
`default_nettype none

module la_decode_chk (
    input logic                    clk,
    input logic                    rstn,
    input logic                    e_allowin,
    input logic                    stall,
    input logic                    d_valid,
    input logic                    d_allowin,
    input logic                    de_valid,
    input la_decode_pkg::de_item_t de_item
);

    int assert_failures = 0;

    // a reset edge always leaves decode empty
    reset_clears_valid: assert property (@(posedge clk) !rstn |=> !de_valid)
        else begin
            assert_failures++;
            $error("de_valid high after a reset cycle");
        end

    held_item_stable: assert property (@(posedge clk) disable iff (!rstn)
        de_valid && !e_allowin |=> $stable(de_item))
        else begin
            assert_failures++;
            $error("de_item changed while execute held it back");
        end

    // a stalled item neither leaves nor lets fetch overwrite it
    stall_holds_item: assert property (@(posedge clk) disable iff (!rstn)
        d_valid && stall |-> !de_valid && !d_allowin)
        else begin
            assert_failures++;
            $error("de_valid or d_allowin high during a load-use stall");
        end

endmodule

bind la_decode_top la_decode_chk u_chk (
    .clk       (clk),
    .rstn      (rstn),
    .e_allowin (e_allowin),
    .stall     (stall),
    .d_valid   (d_valid),
    .d_allowin (d_allowin),
    .de_valid  (de_valid),
    .de_item   (de_item)
);

`default_nettype wire

//--- testbench/tb_la_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_la_decode;
    import la_decode_pkg::*;

    localparam int WAIT_LIMIT = 20;

    logic        clk;
    logic        rstn;
    logic        flush;
    logic        fd_valid;
    fetch_item_t fd_item;
    logic        e_allowin;
    wb_write_t   wb;
    ex_hazard_t  ex_hz;
    logic        d_allowin;
    logic        de_valid;
    de_item_t    de_item;

    // mirrors every write-back
    word_t model_regs [32];
    int    value_errors;
    int    timeouts;
    int    checks;

    la_decode_top DUT (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (flush),
        .fd_valid  (fd_valid),
        .fd_item   (fd_item),
        .e_allowin (e_allowin),
        .wb        (wb),
        .ex_hz     (ex_hz),
        .d_allowin (d_allowin),
        .de_valid  (de_valid),
        .de_item   (de_item)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic end_run();
        int chk_fail;
        chk_fail = DUT.u_chk.assert_failures;
        $display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
                 checks, value_errors, timeouts, chk_fail);
        if (value_errors == 0 && timeouts == 0 && chk_fail == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic check_val(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            value_errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_item(input de_item_t exp, input bit full);
        check_val("de_item.pc", de_item.pc, exp.pc);
        check_val("de_item.dest", word_t'(de_item.dest), word_t'(exp.dest));
        check_val("de_item.gr_we", word_t'(de_item.gr_we), word_t'(exp.gr_we));
        check_val("de_item.ex", word_t'(de_item.ex), word_t'(exp.ex));
        if (exp.ex) begin
            check_val("de_item.ecode", word_t'(de_item.ecode), word_t'(exp.ecode));
        end
        if (full) begin
            check_val("de_item.alu_op", word_t'(de_item.alu_op), word_t'(exp.alu_op));
            check_val("de_item.src1", de_item.src1, exp.src1);
            check_val("de_item.src2", de_item.src2, exp.src2);
            check_val("de_item.store_data", de_item.store_data, exp.store_data);
            check_val("de_item.mem_we", word_t'(de_item.mem_we), word_t'(exp.mem_we));
            check_val("de_item.res_from_mem", word_t'(de_item.res_from_mem),
                      word_t'(exp.res_from_mem));
        end
    endtask

    function automatic word_t rand_pc();
        word_t r;
        r = $urandom();
        return {r[31:2], 2'b00};
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'($urandom_range(31, 0));
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // second read port uses rd for stores, rk otherwise
    function automatic de_item_t expect_base(input word_t pc, input inst_t inst,
                                             input bit store);
        de_item_t  e;
        reg_addr_t a2;
        a2 = store ? inst[4:0] : inst[14:10];
        e.pc           = pc;
        e.alu_op       = ALU_ADD;
        e.src1         = model_regs[inst[9:5]];
        e.src2         = model_regs[a2];
        e.store_data   = model_regs[a2];
        e.dest         = inst[4:0];
        e.gr_we        = !store;
        e.mem_we       = 4'b0000;
        e.res_from_mem = 4'b0000;
        e.ex           = 1'b0;
        e.ecode        = 8'h00;
        return e;
    endfunction

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        @(posedge clk);
        wb <= '{we: 1'b1, addr: addr, data: data};
        @(posedge clk);
        wb <= '0;
        if (addr != 0) begin
            model_regs[addr] = data;
        end
    endtask

    task automatic offer(input word_t pc, input inst_t inst);
        int n;
        n = 0;
        @(negedge clk);
        while (!d_allowin && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!d_allowin) begin
            $display("timeout: decode never allowed a new instruction at %0t", $time);
            timeouts++;
        end else begin
            @(posedge clk);
            fd_valid <= 1'b1;
            fd_item  <= '{pc: pc, inst: inst};
        end
    endtask

    // acceptance edge, optionally with a write-back in the decode cycle
    task automatic finish_offer(input wb_write_t w);
        @(posedge clk);
        fd_valid <= 1'b0;
        wb       <= w;
    endtask

    task automatic wait_de_valid();
        int n;
        n = 0;
        @(negedge clk);
        while (!de_valid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!de_valid) begin
            $display("timeout: no valid instruction left decode at %0t", $time);
            timeouts++;
        end
    endtask

    task automatic issue_check(input word_t pc, input inst_t inst, input de_item_t exp,
                               input bit full);
        offer(pc, inst);
        finish_offer('0);
        wait_de_valid();
        check_item(exp, full);
    endtask

    task automatic run_3r(input logic [1:0] f21, input logic [4:0] f19, input alu_op_e op);
        word_t    pc;
        inst_t    inst;
        de_item_t exp;
        pc         = rand_pc();
        inst       = {6'h00, 4'h0, f21, f19, rand_reg(), rand_reg(), rand_reg()};
        exp        = expect_base(pc, inst, 1'b0);
        exp.alu_op = op;
        issue_check(pc, inst, exp, 1'b1);
    endtask

    task automatic run_shift(input logic [4:0] f19, input alu_op_e op);
        word_t    pc;
        inst_t    inst;
        de_item_t exp;
        pc         = rand_pc();
        inst       = {6'h00, 4'h1, 2'h0, f19, rand_reg(), rand_reg(), rand_reg()};
        exp        = expect_base(pc, inst, 1'b0);
        exp.alu_op = op;
        exp.src2   = {27'b0, inst[14:10]};
        issue_check(pc, inst, exp, 1'b1);
    endtask

    task automatic run_i12(input logic [3:0] f25, input alu_op_e op, input bit signed_imm);
        word_t    pc;
        word_t    r;
        inst_t    inst;
        de_item_t exp;
        pc         = rand_pc();
        r          = $urandom();
        inst       = {6'h00, f25, r[11:0], rand_reg(), rand_reg()};
        exp        = expect_base(pc, inst, 1'b0);
        exp.alu_op = op;
        exp.src2   = signed_imm ? sext12(inst[21:10]) : {20'b0, inst[21:10]};
        issue_check(pc, inst, exp, 1'b1);
    endtask

    task automatic run_u20(input logic [5:0] f31, input alu_op_e op, input bit use_pc);
        word_t    pc;
        word_t    r;
        inst_t    inst;
        de_item_t exp;
        pc         = rand_pc();
        r          = $urandom();
        inst       = {f31, 1'b0, r[19:0], rand_reg()};
        exp        = expect_base(pc, inst, 1'b0);
        exp.alu_op = op;
        exp.src2   = {inst[24:5], 12'h000};
        if (use_pc) begin
            exp.src1 = pc;
        end
        issue_check(pc, inst, exp, 1'b1);
    endtask

    task automatic run_mem(input logic [3:0] f25, input byte_en_t ld, input byte_en_t st);
        word_t    pc;
        word_t    r;
        inst_t    inst;
        de_item_t exp;
        pc               = rand_pc();
        r                = $urandom();
        inst             = {6'h0a, f25, r[11:0], rand_reg(), rand_reg()};
        exp              = expect_base(pc, inst, st != 4'b0000);
        exp.src2         = sext12(inst[21:10]);
        exp.res_from_mem = ld;
        exp.mem_we       = st;
        issue_check(pc, inst, exp, 1'b1);
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_val("de_valid", word_t'(de_valid), 32'h0);
        check_val("d_allowin", word_t'(d_allowin), 32'h1);
    endtask

    task automatic load_regs();
        for (int i = 1; i < 32; i++) begin
            write_reg(reg_addr_t'(i), $urandom());
        end
    endtask

    task automatic test_alu_ops();
        run_3r(2'd1, 5'd0, ALU_ADD);
        run_3r(2'd1, 5'd2, ALU_SUB);
        run_3r(2'd1, 5'd4, ALU_SLT);
        run_3r(2'd1, 5'd5, ALU_SLTU);
        run_3r(2'd1, 5'd8, ALU_NOR);
        run_3r(2'd1, 5'd9, ALU_AND);
        run_3r(2'd1, 5'd10, ALU_OR);
        run_3r(2'd1, 5'd11, ALU_XOR);
        run_3r(2'd1, 5'd14, ALU_SLL);
        run_3r(2'd1, 5'd15, ALU_SRL);
        run_3r(2'd1, 5'd16, ALU_SRA);
        run_3r(2'd1, 5'd24, ALU_MUL);
        run_3r(2'd1, 5'd25, ALU_MULH);
        run_3r(2'd1, 5'd26, ALU_MULHU);
        run_3r(2'd2, 5'd0, ALU_DIV);
        run_3r(2'd2, 5'd1, ALU_MOD);
        run_3r(2'd2, 5'd2, ALU_DIVU);
        run_3r(2'd2, 5'd3, ALU_MODU);
        run_shift(5'd1, ALU_SLL);
        run_shift(5'd9, ALU_SRL);
        run_shift(5'd17, ALU_SRA);
        run_i12(4'd8, ALU_SLT, 1'b1);
        run_i12(4'd9, ALU_SLTU, 1'b1);
        run_i12(4'd10, ALU_ADD, 1'b1);
        run_i12(4'd13, ALU_AND, 1'b0);
        run_i12(4'd14, ALU_OR, 1'b0);
        run_i12(4'd15, ALU_XOR, 1'b0);
        // lu12i.w, then pcaddu12i
        run_u20(6'd5, ALU_LUI, 1'b0);
        run_u20(6'd7, ALU_ADD, 1'b1);
    endtask

    task automatic test_mem_ops();
        run_mem(4'd0, 4'b0001, 4'b0000);
        run_mem(4'd1, 4'b0011, 4'b0000);
        run_mem(4'd2, 4'b1111, 4'b0000);
        run_mem(4'd8, 4'b0101, 4'b0000);
        run_mem(4'd9, 4'b0111, 4'b0000);
        run_mem(4'd4, 4'b0000, 4'b0001);
        run_mem(4'd5, 4'b0000, 4'b0011);
        run_mem(4'd6, 4'b0000, 4'b1111);
    endtask

    task automatic bypass_case(input reg_addr_t rj, input reg_addr_t rk, input reg_addr_t waddr);
        word_t     pc;
        word_t     data;
        inst_t     inst;
        de_item_t  exp;
        wb_write_t w;
        pc   = rand_pc();
        data = $urandom();
        inst = {6'h00, 4'h0, 2'h1, 5'h00, rk, rj, 5'd3};
        exp  = expect_base(pc, inst, 1'b0);
        if (waddr != 0 && waddr == rj) begin
            exp.src1 = data;
        end
        if (waddr != 0 && waddr == rk) begin
            exp.src2       = data;
            exp.store_data = data;
        end
        w = '{we: 1'b1, addr: waddr, data: data};
        offer(pc, inst);
        finish_offer(w);
        wait_de_valid();
        check_item(exp, 1'b1);
        @(posedge clk);
        wb <= '0;
        if (waddr != 0) begin
            model_regs[waddr] = data;
        end
    endtask

    task automatic test_bypass();
        bypass_case(5'd5, 5'd9, 5'd5);
        bypass_case(5'd5, 5'd9, 5'd9);
        bypass_case(5'd0, 5'd9, 5'd0);
        bypass_case(5'd6, 5'd0, 5'd0);
    endtask

    task automatic stall_case(input reg_addr_t hz_dest, input reg_addr_t rj, input reg_addr_t rk);
        word_t    pc;
        inst_t    inst;
        de_item_t exp;
        bit       hazard;
        pc     = rand_pc();
        inst   = {6'h00, 4'h0, 2'h1, 5'h00, rk, rj, 5'd4};
        exp    = expect_base(pc, inst, 1'b0);
        hazard = hz_dest != 0 && (hz_dest == rj || hz_dest == rk);
        offer(pc, inst);
        ex_hz <= '{is_load: 1'b1, dest: hz_dest};
        finish_offer('0);
        if (hazard) begin
            repeat (3) begin
                @(negedge clk);
                check_val("de_valid", word_t'(de_valid), 32'h0);
                check_val("d_allowin", word_t'(d_allowin), 32'h0);
            end
            @(posedge clk);
            ex_hz <= '0;
        end
        wait_de_valid();
        check_item(exp, 1'b1);
        @(posedge clk);
        ex_hz <= '0;
    endtask

    task automatic test_stall();
        stall_case(5'd7, 5'd7, 5'd12);
        stall_case(5'd12, 5'd7, 5'd12);
        stall_case(5'd0, 5'd0, 5'd12);
        stall_case(5'd20, 5'd7, 5'd12);
    endtask

    task automatic test_backpressure();
        word_t    pc;
        inst_t    inst;
        de_item_t exp;
        pc   = rand_pc();
        inst = {6'h00, 4'h0, 2'h1, 5'h02, 5'd8, 5'd9, 5'd10};
        exp  = expect_base(pc, inst, 1'b0);
        exp.alu_op = ALU_SUB;
        offer(pc, inst);
        finish_offer('0);
        e_allowin <= 1'b0;
        wait_de_valid();
        repeat (3) begin
            @(negedge clk);
            check_val("de_valid", word_t'(de_valid), 32'h1);
            check_val("d_allowin", word_t'(d_allowin), 32'h0);
            check_item(exp, 1'b1);
        end
        @(posedge clk);
        e_allowin <= 1'b1;
        @(negedge clk);
        check_val("de_valid", word_t'(de_valid), 32'h1);
        // taken by execute on the next edge
        @(negedge clk);
        check_val("de_valid", word_t'(de_valid), 32'h0);
    endtask

    task automatic test_flush();
        word_t pc;
        inst_t inst;
        pc   = rand_pc();
        inst = {6'h00, 4'h0, 2'h1, 5'h00, 5'd1, 5'd2, 5'd3};
        offer(pc, inst);
        finish_offer('0);
        e_allowin <= 1'b0;
        wait_de_valid();
        @(posedge clk);
        flush    <= 1'b1;
        fd_valid <= 1'b1;
        fd_item  <= '{pc: rand_pc(), inst: inst};
        @(posedge clk);
        e_allowin <= 1'b1;
        @(negedge clk);
        check_val("de_valid", word_t'(de_valid), 32'h0);
        // latch empty and fd_valid high, flush still wins
        @(posedge clk);
        flush    <= 1'b0;
        fd_valid <= 1'b0;
        @(negedge clk);
        check_val("de_valid", word_t'(de_valid), 32'h0);
    endtask

    task automatic exc_case(input inst_t inst, input ecode_t code);
        word_t    pc;
        de_item_t exp;
        pc        = rand_pc();
        exp       = expect_base(pc, inst, 1'b0);
        exp.gr_we = 1'b0;
        exp.ex    = 1'b1;
        exp.ecode = code;
        issue_check(pc, inst, exp, 1'b0);
    endtask

    task automatic test_exceptions();
        exc_case({6'h00, 4'h0, 2'h2, 5'h16, 15'h0000}, ECODE_SYS);
        exc_case({6'h00, 4'h0, 2'h2, 5'h14, 15'h0000}, ECODE_BRK);
        exc_case(32'hffff_ffff, ECODE_INE);
    endtask

    initial begin
        void'($urandom(32'hda7a));
        value_errors = 0;
        timeouts     = 0;
        checks       = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        rstn      = 1'b0;
        flush     = 1'b0;
        fd_valid  = 1'b0;
        fd_item   = '0;
        e_allowin = 1'b1;
        wb        = '0;
        ex_hz     = '0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        test_reset();
        load_regs();
        test_alu_ops();
        test_mem_ops();
        test_bypass();
        test_stall();
        test_backpressure();
        test_flush();
        test_exceptions();
        repeat (2) @(posedge clk);
        end_run();
    end

endmodule

`default_nettype wire
